/* src/zx_pkg.sv */
`default_nettype none

package zx_pkg;

	// ==========================================================
	// Widths and constants
	// ==========================================================
	localparam int unsigned CPU_ADDR_W   = 16;
	localparam int unsigned BANK_W       = 5;
	localparam int unsigned OFFSET_W     = 14;
	localparam int unsigned RAM_CREDITS  = 2;
	localparam int unsigned CREDIT_CNT_W = $clog2(RAM_CREDITS + 1);
	localparam int unsigned TURBO_W      = 5;
	localparam int unsigned DIV_W        = 6;

	// Bank numbers of the 16 KiB RAM space
	localparam logic [BANK_W-1:0] ROM_BANK_BASE  = 5'd8;
	localparam logic [BANK_W-1:0] MF_BANK        = 5'd12;
	localparam logic [BANK_W-1:0] SCREEN_BANK_HI = 5'd5;
	localparam logic [BANK_W-1:0] MID_BANK       = 5'd2;

	// MF128 entry point and port codes
	localparam logic [CPU_ADDR_W-1:0] MF_ENTRY_ADDR    = 16'h0066;
	localparam logic [7:0]            MF_PAGE_IN_PORT  = 8'hBF;
	localparam logic [7:0]            MF_PAGE_OUT_PORT = 8'h3F;

	// Turbo masks, one per speed step
	localparam logic [TURBO_W-1:0] TURBO_NORMAL = 5'b11111;
	localparam logic [TURBO_W-1:0] TURBO_X2     = 5'b01111;
	localparam logic [TURBO_W-1:0] TURBO_X4     = 5'b00111;
	localparam logic [TURBO_W-1:0] TURBO_X8     = 5'b00011;
	localparam logic [TURBO_W-1:0] TURBO_X16    = 5'b00001;

	// ==========================================================
	// Bus types
	// ==========================================================
	typedef struct packed {
		logic [1:0]          window;
		logic [OFFSET_W-1:0] offset;
	} mem_view_t;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} io_view_t;

	// Same address word, seen by the memory path or the port path
	typedef union packed {
		mem_view_t mem_view;
		io_view_t  io_view;
	} cpu_addr_u;

	typedef struct packed {
		cpu_addr_u  addr;
		logic [7:0] dout;
		logic       mreq;
		logic       iorq;
		logic       rd;
		logic       wr;
		logic       m1;
	} cpu_bus_t;

	typedef struct packed {
		logic [BANK_W-1:0]   bank;
		logic [OFFSET_W-1:0] offset;
	} ram_addr_t;

	typedef struct packed {
		ram_addr_t  addr;
		logic [7:0] wdata;
		logic       we;
		logic       valid;
	} ram_req_t;

	typedef struct packed {
		logic [2:0] ram_page;
		logic       rom_sel;
		logic       scr_copy;
		logic       mf_mem;
	} page_state_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_state_t;

endpackage

`default_nettype wire

/* src/cpu_clock_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_clock_ctrl (
	input  wire logic                     clk_sys,
	input  wire logic                     reset,
	input  wire logic [4:0]               fn_keys,
	input  wire logic                     credit_avail,
	output logic                          cpu_ce
);

	logic [zx_pkg::DIV_W-1:0]   divider;
	logic [zx_pkg::TURBO_W-1:0] turbo;
	logic [zx_pkg::TURBO_W-1:0] turbo_key;
	logic [4:0]                 fn_prev;
	logic [4:0]                 key_rise;
	logic [1:0]                 timeout;
	logic                       pause;
	logic                       cpu_en;
	logic                       slot;

	// ==========================================================
	// Enable slots from the free-running divider
	// ==========================================================
	// A slot comes when every divider bit under the mask is zero
	assign slot = ((divider & {1'b0, turbo}) == '0);

	assign key_rise = fn_keys & ~fn_prev;

	// Keys 0 to 3 pick x2 to x16, the key of the active step goes back to normal
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			divider   <= '0;
			fn_prev   <= '0;
			turbo_key <= zx_pkg::TURBO_NORMAL;
			pause     <= 1'b0;
		end else begin
			divider <= divider + 1'b1;
			fn_prev <= fn_keys;
			if (key_rise[0])
				turbo_key <= (turbo_key == zx_pkg::TURBO_X2) ? zx_pkg::TURBO_NORMAL :
					zx_pkg::TURBO_X2;
			if (key_rise[1])
				turbo_key <= (turbo_key == zx_pkg::TURBO_X4) ? zx_pkg::TURBO_NORMAL :
					zx_pkg::TURBO_X4;
			if (key_rise[2])
				turbo_key <= (turbo_key == zx_pkg::TURBO_X8) ? zx_pkg::TURBO_NORMAL :
					zx_pkg::TURBO_X8;
			if (key_rise[3])
				turbo_key <= (turbo_key == zx_pkg::TURBO_X16) ? zx_pkg::TURBO_NORMAL :
					zx_pkg::TURBO_X16;
			if (key_rise[4])
				pause <= ~pause;
		end
	end

	// ==========================================================
	// Turbo switch and enable control
	// ==========================================================
	// Timeout runs 1, 2, 3, 0 so the CPU sits out at least four slots
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo   <= zx_pkg::TURBO_NORMAL;
			timeout <= '0;
			cpu_en  <= 1'b0;
		end else if (slot) begin
			if (timeout != '0)
				timeout <= timeout + 1'b1;
			if (turbo != turbo_key) begin
				cpu_en  <= 1'b0;
				timeout <= 2'd1;
				turbo   <= turbo_key;
			end else if (!cpu_en && timeout == '0 && credit_avail) begin
				cpu_en <= ~pause;
			end else if (cpu_en && pause) begin
				cpu_en <= 1'b0;
			end
		end
	end

	// Pause and memory back-pressure hold the CPU at once
	assign cpu_ce = cpu_en & slot & ~pause & credit_avail;

endmodule

`default_nettype wire

/* src/paging_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module paging_unit (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire zx_pkg::cpu_bus_t    cpu_bus,
	output zx_pkg::page_state_t      page_state
);

	logic [5:0] page_reg;
	logic       scr_copy;
	logic       mf_en;
	logic       mf_mem;
	logic       io_rd;
	logic       io_wr;
	logic       page_wr;
	logic       m1_fetch;
	logic       page_wr_q;
	logic       io_rd_q;
	logic       m1_fetch_q;

	// ==========================================================
	// Strobe decode
	// ==========================================================
	assign io_wr    = cpu_bus.iorq & cpu_bus.wr & ~cpu_bus.m1;
	assign io_rd    = cpu_bus.iorq & cpu_bus.rd & ~cpu_bus.m1;
	assign m1_fetch = cpu_bus.mreq & cpu_bus.m1;

	// 7FFD is decoded on A15 and A1 low
	assign page_wr = io_wr & ~cpu_bus.addr.io_view.hi[7] & ~cpu_bus.addr.io_view.lo[1];

	// ==========================================================
	// 7FFD page register
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_wr_q <= 1'b0;
			page_reg  <= '0;
			scr_copy  <= 1'b0;
		end else begin
			page_wr_q <= page_wr;
			// Bit 5 locks the register until reset
			if (page_wr && !page_wr_q && !page_reg[5]) begin
				page_reg <= cpu_bus.dout[5:0];
				if (!mf_mem)
					scr_copy <= page_reg[3];
			end
		end
	end

	// ==========================================================
	// MF128 overlay
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_rd_q    <= 1'b0;
			m1_fetch_q <= 1'b0;
			mf_en      <= 1'b0;
			mf_mem     <= 1'b0;
		end else begin
			io_rd_q    <= io_rd;
			m1_fetch_q <= m1_fetch;
			if (io_rd && !io_rd_q) begin
				if (cpu_bus.addr.io_view.lo == zx_pkg::MF_PAGE_IN_PORT && mf_en)
					mf_mem <= 1'b1;
				if (cpu_bus.addr.io_view.lo == zx_pkg::MF_PAGE_OUT_PORT)
					mf_mem <= 1'b0;
			end
			// NMI entry arms the overlay until reset
			if (m1_fetch && !m1_fetch_q && cpu_bus.addr == zx_pkg::MF_ENTRY_ADDR) begin
				mf_en  <= 1'b1;
				mf_mem <= 1'b1;
			end
		end
	end

	always_comb begin
		page_state.ram_page = page_reg[2:0];
		page_state.rom_sel  = page_reg[4];
		page_state.scr_copy = scr_copy;
		page_state.mf_mem   = mf_mem;
	end

endmodule

`default_nettype wire

/* src/ram_request_port.sv */
`timescale 1ns/1ns
`default_nettype none

module ram_request_port (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire zx_pkg::cpu_bus_t     cpu_bus,
	input  wire zx_pkg::page_state_t  page_state,
	input  wire logic                 ram_credit,
	output zx_pkg::ram_req_t          ram_req,
	output logic                      credit_avail
);

	logic [zx_pkg::CREDIT_CNT_W-1:0] credits;
	logic                            mem_cyc;
	logic                            mem_cyc_q;
	logic                            wr_allowed;
	logic                            req_edge;
	logic                            has_credit;
	logic                            issue_pend;
	logic                            issue_new;
	logic                            hold_new;
	logic                            spend;
	zx_pkg::ram_addr_t               new_addr;
	zx_pkg::ram_addr_t               pend_addr;
	logic [7:0]                      pend_wdata;
	logic                            pend_we;
	logic                            pend_valid;
	zx_pkg::ram_addr_t               req_addr;
	logic [7:0]                      req_wdata;
	logic                            req_we;
	logic                            req_valid;

	// ==========================================================
	// Window to bank mapping
	// ==========================================================
	always_comb begin
		new_addr.offset = cpu_bus.addr.mem_view.offset;
		case (cpu_bus.addr.mem_view.window)
			2'd0: new_addr.bank = page_state.mf_mem ? zx_pkg::MF_BANK :
				zx_pkg::ROM_BANK_BASE + zx_pkg::BANK_W'(page_state.rom_sel);
			2'd1: new_addr.bank = zx_pkg::SCREEN_BANK_HI;
			2'd2: new_addr.bank = zx_pkg::MID_BANK;
			default: new_addr.bank = zx_pkg::BANK_W'(page_state.ram_page);
		endcase
	end

	// ROM is read-only, only the MF128 RAM half of window 0 takes writes
	assign wr_allowed = (cpu_bus.addr.mem_view.window != 2'd0) ||
		(page_state.mf_mem && cpu_bus.addr.mem_view.offset[13]);

	assign mem_cyc  = cpu_bus.mreq & (cpu_bus.rd | cpu_bus.wr);
	assign req_edge = mem_cyc & ~mem_cyc_q & (~cpu_bus.wr | wr_allowed);

	// ==========================================================
	// Credit and issue control
	// ==========================================================
	// A credit returned this cycle can be spent at once
	assign has_credit = (credits != '0) || ram_credit;
	assign issue_pend = pend_valid && has_credit;
	assign issue_new  = req_edge && has_credit && !pend_valid;
	assign hold_new   = req_edge && !issue_new;
	assign spend      = issue_pend || issue_new;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_cyc_q  <= 1'b0;
			credits    <= zx_pkg::CREDIT_CNT_W'(zx_pkg::RAM_CREDITS);
			pend_valid <= 1'b0;
			req_valid  <= 1'b0;
		end else begin
			mem_cyc_q <= mem_cyc;
			req_valid <= spend;
			if (ram_credit && !spend)
				credits <= credits + 1'b1;
			else if (spend && !ram_credit)
				credits <= credits - 1'b1;
			if (hold_new)
				pend_valid <= 1'b1;
			else if (issue_pend)
				pend_valid <= 1'b0;
		end
	end

	// Payload registers
	always_ff @(posedge clk_sys) begin
		if (hold_new) begin
			pend_addr  <= new_addr;
			pend_wdata <= cpu_bus.dout;
			pend_we    <= cpu_bus.wr;
		end
		if (issue_pend) begin
			req_addr  <= pend_addr;
			req_wdata <= pend_wdata;
			req_we    <= pend_we;
		end else if (issue_new) begin
			req_addr  <= new_addr;
			req_wdata <= cpu_bus.dout;
			req_we    <= cpu_bus.wr;
		end
	end

	always_comb begin
		ram_req.addr  = req_addr;
		ram_req.wdata = req_wdata;
		ram_req.we    = req_we;
		ram_req.valid = req_valid;
	end

	// CPU stalls once credits are gone or a request waits
	assign credit_avail = (credits != '0) && !pend_valid;

endmodule

`default_nettype wire

/* src/ula_io.sv */
`timescale 1ns/1ns
`default_nettype none

module ula_io (
	input  wire logic                 clk_sys,
	input  wire logic                 reset,
	input  wire zx_pkg::cpu_bus_t     cpu_bus,
	input  wire zx_pkg::page_state_t  page_state,
	input  wire logic [4:0]           kbd_row,
	input  wire logic [7:0]           ram_rdata,
	output zx_pkg::ula_state_t        ula_state,
	output logic [7:0]                cpu_din
);

	logic ula_we;
	logic ula_we_q;
	logic io_rd;
	logic mem_rd;
	logic port_bf;

	// ==========================================================
	// ULA port latch
	// ==========================================================
	// Any even port address reaches the ULA
	assign ula_we = cpu_bus.iorq & cpu_bus.wr & ~cpu_bus.m1 & ~cpu_bus.addr.io_view.lo[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_we_q  <= 1'b0;
			ula_state <= '0;
		end else begin
			ula_we_q <= ula_we;
			if (ula_we && !ula_we_q) begin
				ula_state.border <= cpu_bus.dout[2:0];
				ula_state.ear    <= cpu_bus.dout[4];
				ula_state.mic    <= cpu_bus.dout[3];
			end
		end
	end

	// ==========================================================
	// CPU read-data mux
	// ==========================================================
	assign mem_rd  = cpu_bus.mreq & cpu_bus.rd;
	assign io_rd   = cpu_bus.iorq & cpu_bus.rd & ~cpu_bus.m1;

	// Screen page readback, only while the MF128 is paged in
	assign port_bf = (cpu_bus.addr.io_view.lo == zx_pkg::MF_PAGE_IN_PORT) &
		page_state.mf_mem;

	always_comb begin
		if (mem_rd)
			cpu_din = ram_rdata;
		else if (io_rd && port_bf)
			cpu_din = {page_state.scr_copy, 7'b1111111};
		else if (io_rd && !cpu_bus.addr.io_view.lo[0])
			cpu_din = {3'b111, kbd_row};
		else
			cpu_din = 8'hFF;
	end

endmodule

`default_nettype wire

/* src/zx_host.sv */
`timescale 1ns/1ns
`default_nettype none

module zx_host (
	input  wire logic               clk_sys,
	input  wire logic               reset,
	input  wire zx_pkg::cpu_bus_t   cpu_bus,
	input  wire logic [4:0]         fn_keys,
	input  wire logic [4:0]         kbd_row,
	input  wire logic               ram_credit,
	input  wire logic [7:0]         ram_rdata,
	output logic                    cpu_ce,
	output zx_pkg::ram_req_t        ram_req,
	output zx_pkg::ula_state_t      ula_state,
	output logic [7:0]              cpu_din
);

	zx_pkg::page_state_t page_state;
	logic                credit_avail;

	// ==========================================================
	// CPU clock enable
	// ==========================================================
	cpu_clock_ctrl i_cpu_clock_ctrl (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.fn_keys      (fn_keys),
		.credit_avail (credit_avail),
		.cpu_ce       (cpu_ce)
	);

	// ==========================================================
	// Paging and memory requests
	// ==========================================================
	paging_unit i_paging_unit (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_bus    (cpu_bus),
		.page_state (page_state)
	);

	ram_request_port i_ram_request_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_bus      (cpu_bus),
		.page_state   (page_state),
		.ram_credit   (ram_credit),
		.ram_req      (ram_req),
		.credit_avail (credit_avail)
	);

	// ULA port and read data back to the CPU
	ula_io i_ula_io (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_bus    (cpu_bus),
		.page_state (page_state),
		.kbd_row    (kbd_row),
		.ram_rdata  (ram_rdata),
		.ula_state  (ula_state),
		.cpu_din    (cpu_din)
	);

endmodule

`default_nettype wire

/* testbench/tb_zx_table.svh */
`ifndef TB_ZX_TABLE_SVH
`define TB_ZX_TABLE_SVH

// Row columns: op, CPU address, data byte, expected value
// Request rows expect {we, bank, offset}, zero means no request
// OP_KEY rows take the key index as data and the cpu_ce gap as expected value
localparam logic [3:0] OP_RD      = 4'd0;
localparam logic [3:0] OP_WR      = 4'd1;
localparam logic [3:0] OP_M1      = 4'd2;
localparam logic [3:0] OP_IOWR    = 4'd3;
localparam logic [3:0] OP_IORD    = 4'd4;
localparam logic [3:0] OP_ULA     = 4'd5;
localparam logic [3:0] OP_KEY     = 4'd6;
localparam logic [3:0] OP_RD_NW   = 4'd7;
localparam logic [3:0] OP_HOLD    = 4'd8;
localparam logic [3:0] OP_CE_LOW  = 4'd9;
localparam logic [3:0] OP_RELEASE = 4'd10;

typedef struct packed {
	logic [3:0]  op;
	logic [15:0] addr;
	logic [7:0]  data;
	logic [19:0] expect_val;
} test_row_t;

localparam int NUM_ROWS = 40;

localparam test_row_t TEST_ROWS [0:NUM_ROWS-1] = '{
	// Fixed windows and page 0
	'{OP_RD, 16'h4001, 8'h00, 20'h14001}, '{OP_RD, 16'h8123, 8'h00, 20'h08123},
	'{OP_RD, 16'hC456, 8'h00, 20'h00456},
	// 7FFD paging, then lock
	'{OP_IOWR, 16'h7FFD, 8'h03, 20'h0}, '{OP_RD, 16'hC456, 8'h00, 20'h0C456},
	'{OP_RD, 16'h0200, 8'h00, 20'h20200},
	'{OP_IOWR, 16'h7FFD, 8'h14, 20'h0}, '{OP_RD, 16'hC000, 8'h00, 20'h10000},
	'{OP_RD, 16'h0200, 8'h00, 20'h24200},
	'{OP_IOWR, 16'h7FFD, 8'h26, 20'h0}, '{OP_RD, 16'hC010, 8'h00, 20'h18010},
	'{OP_RD, 16'h0300, 8'h00, 20'h20300},
	'{OP_IOWR, 16'h7FFD, 8'h01, 20'h0}, '{OP_RD, 16'hC010, 8'h00, 20'h18010},
	// MF128 overlay
	'{OP_WR, 16'h1234, 8'h5A, 20'h0}, '{OP_M1, 16'h0066, 8'h00, 20'h20066},
	'{OP_RD, 16'h0100, 8'h00, 20'h30100}, '{OP_WR, 16'h2010, 8'hA5, 20'hB2010},
	'{OP_WR, 16'h0010, 8'h33, 20'h0}, '{OP_IORD, 16'h00BF, 8'h00, 20'h0007F},
	'{OP_IORD, 16'h003F, 8'h00, 20'h000FF}, '{OP_RD, 16'h0100, 8'h00, 20'h20100},
	'{OP_IORD, 16'h00BF, 8'h00, 20'h000FF}, '{OP_RD, 16'h0100, 8'h00, 20'h30100},
	// ULA port and keyboard
	'{OP_IOWR, 16'h00FE, 8'h1D, 20'h0}, '{OP_ULA, 16'h0000, 8'h00, 20'h00017},
	'{OP_IORD, 16'h00FE, 8'h00, 20'h000EA},
	// Turbo keys, x16 key again returns to normal
	'{OP_KEY, 16'h0000, 8'd0, 20'd16}, '{OP_KEY, 16'h0000, 8'd1, 20'd8},
	'{OP_KEY, 16'h0000, 8'd2, 20'd4}, '{OP_KEY, 16'h0000, 8'd3, 20'd2},
	'{OP_KEY, 16'h0000, 8'd3, 20'd32},
	// Pause on, then off
	'{OP_KEY, 16'h0000, 8'd4, 20'd0}, '{OP_KEY, 16'h0000, 8'd4, 20'd32},
	// Back-pressure
	'{OP_HOLD, 16'h0000, 8'h00, 20'h0}, '{OP_RD_NW, 16'h4100, 8'h00, 20'h14100},
	'{OP_RD_NW, 16'h8200, 8'h00, 20'h08200}, '{OP_RD_NW, 16'hC300, 8'h00, 20'h18300},
	'{OP_CE_LOW, 16'h0000, 8'h00, 20'h0}, '{OP_RELEASE, 16'h0000, 8'h00, 20'h0}
};

`endif

/* testbench/tb_zx_host.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_zx_host;

	`include "tb_zx_table.svh"

	localparam int CE_LIMIT  = 400;
	localparam int REQ_LIMIT = 150;

	logic                clk_sys;
	logic                reset;
	zx_pkg::cpu_bus_t    cpu_bus;
	logic [4:0]          fn_keys;
	logic [4:0]          kbd_row;
	logic                ram_credit;
	logic [7:0]          ram_rdata;
	logic                cpu_ce;
	zx_pkg::ram_req_t    ram_req;
	zx_pkg::ula_state_t  ula_state;
	logic [7:0]          cpu_din;

	// Expected request entries hold {wdata, we, bank, offset}
	logic [27:0]         exp_q[$];
	logic [27:0]         exp_req;
	logic [18:0]         mem_q[$];
	int                  mem_wait;
	int                  issued;
	int                  credited;
	logic                withhold;

	zx_host i_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_bus    (cpu_bus),
		.fn_keys    (fn_keys),
		.kbd_row    (kbd_row),
		.ram_credit (ram_credit),
		.ram_rdata  (ram_rdata),
		.cpu_ce     (cpu_ce),
		.ram_req    (ram_req),
		.ula_state  (ula_state),
		.cpu_din    (cpu_din)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp_val);
		if (got !== exp_val) begin
			$display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp_val);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic stop_run(string what);
		$display("Error at %0t: %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped");
	endtask

	// Fill pattern folds the whole bank and offset into one byte
	function automatic logic [7:0] mem_pattern(logic [18:0] a);
		return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
	endfunction

	// ==========================================================
	// Memory model and request monitor
	// ==========================================================
	always @(posedge clk_sys) begin
		ram_credit <= 1'b0;
		if (!reset) begin
			if (ram_credit)
				credited++;
			if (ram_req.valid) begin
				issued++;
				if (exp_q.size() == 0)
					stop_run("memory request appeared where none was expected");
				exp_req = exp_q.pop_front();
				check_value("ram_req", {12'b0, ram_req.we, ram_req.addr},
					{12'b0, exp_req[19:0]});
				if (exp_req[19])
					check_value("ram_req.wdata", {24'b0, ram_req.wdata},
						{24'b0, exp_req[27:20]});
				if (mem_q.size() == 0)
					mem_wait = 1 + int'($urandom % 6);
				mem_q.push_back(ram_req.addr);
			end
			check_value("outstanding_over_limit",
				{31'b0, (issued - credited) > int'(zx_pkg::RAM_CREDITS)}, 32'd0);
			if (!withhold && mem_q.size() > 0) begin
				if (mem_wait > 1) begin
					mem_wait--;
				end else begin
					ram_credit <= 1'b1;
					ram_rdata  <= mem_pattern(mem_q.pop_front());
					mem_wait   = 1 + int'($urandom % 6);
				end
			end
		end
	end

	// ==========================================================
	// Bus and key drivers
	// ==========================================================
	task automatic bus_cycle(logic [4:0] strobes, logic [15:0] addr, logic [7:0] data,
		logic check_din, logic [7:0] exp_din);
		zx_pkg::cpu_bus_t bus;
		bus      = '0;
		bus.addr = zx_pkg::cpu_addr_u'(addr);
		bus.dout = data;
		{bus.mreq, bus.iorq, bus.rd, bus.wr, bus.m1} = strobes;
		@(posedge clk_sys);
		cpu_bus <= bus;
		@(negedge clk_sys);
		if (check_din)
			check_value("cpu_din", {24'b0, cpu_din}, {24'b0, exp_din});
		else if (strobes[4] && strobes[2])
			// Memory reads see the byte the memory model drives
			check_value("cpu_din", {24'b0, cpu_din}, {24'b0, ram_rdata});
		repeat (3) @(posedge clk_sys);
		cpu_bus <= '0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic wait_requests();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk_sys);
			n++;
			if (n > REQ_LIMIT)
				stop_run("timed out waiting for expected memory requests");
		end
	endtask

	task automatic press_key(int idx);
		@(posedge clk_sys);
		fn_keys <= 5'(1 << idx);
		repeat (2) @(posedge clk_sys);
		fn_keys <= '0;
		@(posedge clk_sys);
	endtask

	task automatic wait_ce(output int cycles);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > CE_LIMIT)
				stop_run("timed out waiting for a cpu_ce pulse");
		end while (!cpu_ce);
		cycles = n;
	endtask

	task automatic check_ce_low(int cycles);
		repeat (cycles) begin
			@(negedge clk_sys);
			check_value("cpu_ce", {31'b0, cpu_ce}, 32'd0);
		end
	endtask

	task automatic run_row(test_row_t row);
		int gap;
		case (row.op)
			OP_RD, OP_RD_NW, OP_M1: begin
				exp_q.push_back({row.data, row.expect_val});
				bus_cycle((row.op == OP_M1) ? 5'b10101 : 5'b10100, row.addr, row.data,
					1'b0, 8'h00);
				if (row.op != OP_RD_NW)
					wait_requests();
			end
			OP_WR: begin
				if (row.expect_val != '0)
					exp_q.push_back({row.data, row.expect_val});
				bus_cycle(5'b10010, row.addr, row.data, 1'b0, 8'h00);
				repeat (8) @(posedge clk_sys);
				wait_requests();
			end
			OP_IOWR: bus_cycle(5'b01010, row.addr, row.data, 1'b0, 8'h00);
			OP_IORD: bus_cycle(5'b01100, row.addr, row.data, 1'b1, row.expect_val[7:0]);
			OP_ULA: check_value("ula_state", {27'b0, ula_state}, {12'b0, row.expect_val});
			OP_KEY: begin
				press_key(int'(row.data));
				if (row.expect_val == '0) begin
					check_ce_low(200);
				end else begin
					repeat (3) wait_ce(gap);
					wait_ce(gap);
					check_value("cpu_ce_gap", gap, {12'b0, row.expect_val});
				end
			end
			OP_HOLD: withhold = 1'b1;
			OP_CE_LOW: check_ce_low(100);
			OP_RELEASE: begin
				withhold = 1'b0;
				wait_requests();
			end
			default: stop_run("table row holds an unknown operation");
		endcase
	endtask

	initial begin
		void'($urandom(32'h92a5_75a1));
		reset      = 1'b1;
		cpu_bus    = '0;
		fn_keys    = '0;
		kbd_row    = 5'h0A;
		ram_credit = 1'b0;
		ram_rdata  = '0;
		withhold   = 1'b0;
		mem_wait   = 0;
		issued     = 0;
		credited   = 0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (4) @(posedge clk_sys);
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(TEST_ROWS[i]);
		repeat (10) @(posedge clk_sys);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+testbench
src/zx_pkg.sv
src/cpu_clock_ctrl.sv
src/paging_unit.sv
src/ram_request_port.sv
src/ula_io.sv
src/zx_host.sv
testbench/tb_zx_host.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_zx_host -o tb_zx_host_sim \
	&& sim_out=$(./obj_dir/tb_zx_host_sim 2>&1; true) \
	&& echo "$sim_out" \
	&& echo "$sim_out" | grep -q "^STATUS: PASS$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
